// File: source/trace_pkg.sv
// trace unit package: widths, bus phase codes, bus/event/record structs
package trace_pkg;

////////////////////
// sizes

    localparam int xlen   = 32;  // data and address width
    localparam int n_hart = 4;   // harts sharing the bus, one lane each
    localparam int hart_w = 2;   // hart id width
    localparam int widx_w = 5;   // gpr index width
    localparam int drop_w = 8;   // per-lane drop counter width

////////////////////
// encodings

    // bus phase codes, as driven by the core FSM
    typedef enum logic [2:0] {
        ph_if  = 3'b000,  // instruction fetch
        ph_mld = 3'b001,  // memory load
        ph_mst = 3'b010,  // memory store
        ph_exe = 3'b011,  // execute, branch condition only
        ph_wb  = 3'b100,  // gpr write-back
        ph_rs1 = 3'b101,  // gpr read rs1
        ph_rs2 = 3'b110   // gpr read rs2
    } phase_e;

    // memory access carried by a record
    typedef enum logic [1:0] {
        ls_none  = 2'd0,
        ls_load  = 2'd1,
        ls_store = 2'd2
    } ls_kind_e;

////////////////////
// structs

    typedef struct packed {
        logic [hart_w-1:0] hart;  // requesting hart
        logic [2:0]        pha;   // raw phase code
        logic              wen;   // write enable
        logic [1:0]        siz;   // log2 of byte count
        logic [xlen-1:0]   adr;
        logic [xlen-1:0]   wdt;
    } bus_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdt;  // read data, one cycle after the request
    } bus_rsp_t;

    // one observed transfer, request joined with its response
    typedef struct packed {
        logic [hart_w-1:0] hart;
        phase_e            pha;
        logic [xlen-1:0]   adr;
        logic [xlen-1:0]   wdt;
        logic [1:0]        siz;
        logic [xlen-1:0]   rdt;
    } tap_event_t;

    // one retired instruction
    typedef struct packed {
        logic [hart_w-1:0] hart;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   ins;
        logic              wb_ena;  // gpr written
        logic [widx_w-1:0] wb_idx;
        logic [xlen-1:0]   wb_dat;
        ls_kind_e          ls_kind;
        logic [xlen-1:0]   ls_adr;
        logic [1:0]        ls_siz;
        logic [xlen-1:0]   ls_dat;  // store data or load data
    } trace_rec_t;

endpackage

// File: source/trace_router.sv
// bus tap router: joins each transfer with its response and steers it to a hart lane
`timescale 1ns/1ns

module trace_router
    import trace_pkg::*;
(
    input  logic              tcb,
    input  logic              rst_n,
    input  logic              bus_vld,
    input  logic              bus_rdy,
    input  bus_req_t          bus_req,
    input  bus_rsp_t          bus_rsp,
    output logic [n_hart-1:0] lane_vld,
    output tap_event_t        evt
);

    logic     trn;    // transfer this cycle
    logic     trn_q;  // transfer last cycle, response is on the bus now
    bus_req_t req_q;  // request of last transfer
    phase_e   pha;    // decoded phase

    assign trn = bus_vld & bus_rdy;

////////////////////
// request delay

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            trn_q <= 1'b0;
        end else begin
            trn_q <= trn;
        end
    end

    always_ff @(posedge tcb) begin
        if (trn) begin
            req_q <= bus_req;  // payload only
        end
    end

////////////////////
// decode and steer

    // unused code 3'b111 folds into exe, which no lane logs
    always_comb begin
        if (req_q.pha == 3'b111) begin
            pha = ph_exe;
        end else begin
            pha = phase_e'(req_q.pha);
        end
    end

    assign lane_vld = trn_q ? (n_hart'(1) << req_q.hart) : '0;  // one-hot per hart

    always_comb begin
        evt.hart = req_q.hart;
        evt.pha  = pha;
        evt.adr  = req_q.adr;
        evt.wdt  = req_q.wdt;
        evt.siz  = req_q.siz;
        evt.rdt  = bus_rsp.rdt;  // response belongs to the held request
    end

endmodule

// File: source/trace_assembler.sv
// per-hart record assembler: collects the phases of one instruction into a trace record
`timescale 1ns/1ns

module trace_assembler
    import trace_pkg::*;
(
    input  logic              tcb,
    input  logic              rst_n,
    input  logic              evt_vld,
    input  tap_event_t        evt,
    output logic              rec_vld,
    output trace_rec_t        rec,
    input  logic              rec_rdy,
    output logic [drop_w-1:0] drop_cnt
);

    logic       col_act;    // a record is being collected
    trace_rec_t cur;        // record under construction
    logic       slot_vld;   // output slot full
    trace_rec_t slot;       // output slot
    logic       is_if;      // fetch event for this hart
    logic       slot_free;  // slot empty or draining this cycle
    logic       push;       // finished record goes to slot
    logic       drop;       // finished record lost

    assign is_if     = evt_vld && (evt.pha == ph_if);
    assign slot_free = !slot_vld || rec_rdy;
    assign push      = is_if && col_act && slot_free;
    assign drop      = is_if && col_act && !slot_free;

////////////////////
// control

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            col_act  <= 1'b0;
            slot_vld <= 1'b0;
            drop_cnt <= '0;
        end else begin
            if (is_if) begin
                col_act <= 1'b1;  // first fetch only opens
            end
            if (push) begin
                slot_vld <= 1'b1;
            end else if (rec_rdy) begin
                slot_vld <= 1'b0;  // taken by arbiter
            end
            // saturating
            if (drop && (drop_cnt != '1)) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

////////////////////
// record collection

    always_ff @(posedge tcb) begin
        if (push) begin
            slot <= cur;  // close previous instruction
        end
        if (evt_vld) begin
            case (evt.pha)
                ph_if: begin
                    // open new record, wb and ls fields cleared
                    cur <= '{hart: evt.hart, pc: evt.adr, ins: evt.rdt,
                             ls_kind: ls_none, default: '0};
                end
                ph_wb: begin
                    cur.wb_ena <= 1'b1;
                    cur.wb_idx <= evt.adr[6:2];  // gpr index from word address
                    cur.wb_dat <= evt.wdt;
                end
                ph_mld: begin
                    cur.ls_kind <= ls_load;
                    cur.ls_adr  <= evt.adr;
                    cur.ls_siz  <= evt.siz;
                    cur.ls_dat  <= evt.rdt;  // load data from response
                end
                ph_mst: begin
                    cur.ls_kind <= ls_store;
                    cur.ls_adr  <= evt.adr;
                    cur.ls_siz  <= evt.siz;
                    cur.ls_dat  <= evt.wdt;  // store data from request
                end
                default: begin
                    // rs1, rs2 and exe are not logged
                end
            endcase
        end
    end

    assign rec_vld = slot_vld;
    assign rec     = slot;

endmodule

// File: source/trace_arbiter.sv
// round-robin merge of lane records into one registered output stream
`timescale 1ns/1ns

module trace_arbiter
    import trace_pkg::*;
(
    input  logic              tcb,
    input  logic              rst_n,
    input  logic [n_hart-1:0] rec_vld,
    input  trace_rec_t        rec [n_hart],
    output logic [n_hart-1:0] rec_rdy,
    output logic              out_vld,
    output trace_rec_t        out_rec,
    input  logic              out_rdy
);

    logic              load;  // output register empty or draining
    logic              any;   // some lane has a record
    logic [hart_w-1:0] sel;   // granted lane
    logic [hart_w-1:0] last;  // previous winner
    logic [hart_w-1:0] idx;   // search position

    assign load = !out_vld || out_rdy;

////////////////////
// grant

    // search starts one past the last winner, wraps at n_hart
    always_comb begin
        any = 1'b0;
        sel = last;
        idx = last;
        for (int i = 1; i <= n_hart; i++) begin
            idx = hart_w'(last + i);
            if (!any && rec_vld[idx]) begin
                any = 1'b1;
                sel = idx;
            end
        end
    end

    always_comb begin
        rec_rdy = '0;
        if (load && any) begin
            rec_rdy[sel] = 1'b1;  // one lane at most
        end
    end

////////////////////
// output register

    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
            last    <= hart_w'(n_hart - 1);  // lane 0 wins first
        end else if (load) begin
            out_vld <= any;
            if (any) begin
                last <= sel;
            end
        end
    end

    always_ff @(posedge tcb) begin
        if (load && any) begin
            out_rec <= rec[sel];
        end
    end

endmodule

// File: source/trace_top.sv
// trace unit top: bus tap router, per-hart assemblers and output arbiter
`timescale 1ns/1ns

module trace_top
    import trace_pkg::*;
(
    input  logic                           tcb,
    input  logic                           rst_n,
    input  logic                           bus_vld,
    input  logic                           bus_rdy,
    input  bus_req_t                       bus_req,
    input  bus_rsp_t                       bus_rsp,
    output logic                           out_vld,
    output trace_rec_t                     out_rec,
    input  logic                           out_rdy,
    output logic [n_hart-1:0][drop_w-1:0] drop_cnt
);

    logic [n_hart-1:0] lane_vld;  // one-hot event valid
    tap_event_t        evt;       // shared by all lanes
    logic [n_hart-1:0] rec_vld;
    logic [n_hart-1:0] rec_rdy;
    trace_rec_t        rec [n_hart];

    trace_router u_router (
        .tcb      (tcb),
        .rst_n    (rst_n),
        .bus_vld  (bus_vld),
        .bus_rdy  (bus_rdy),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .lane_vld (lane_vld),
        .evt      (evt)
    );

    // one assembler per hart
    for (genvar g = 0; g < n_hart; g++) begin : g_lane
        trace_assembler u_asm (
            .tcb      (tcb),
            .rst_n    (rst_n),
            .evt_vld  (lane_vld[g]),
            .evt      (evt),
            .rec_vld  (rec_vld[g]),
            .rec      (rec[g]),
            .rec_rdy  (rec_rdy[g]),
            .drop_cnt (drop_cnt[g])
        );
    end

    trace_arbiter u_arb (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .rec_vld (rec_vld),
        .rec     (rec),
        .rec_rdy (rec_rdy),
        .out_vld (out_vld),
        .out_rec (out_rec),
        .out_rdy (out_rdy)
    );

endmodule

// File: tests/tb_trace_top.sv
// trace unit testbench: bus model, reference records per hart, output compare and watchdog
`timescale 1ns/1ns

module tb_trace_top
    import trace_pkg::*;
();

    localparam int n_rand = 400;  // transfers per random phase

    logic                          tcb;
    logic                          rst_n;
    logic                          bus_vld;
    logic                          bus_rdy;
    bus_req_t                      bus_req;
    bus_rsp_t                      bus_rsp;
    logic                          out_vld;
    trace_rec_t                    out_rec;
    logic                          out_rdy;
    logic [n_hart-1:0][drop_w-1:0] drop_cnt;

    trace_rec_t      exp_q [n_hart][$];  // expected records, program order
    trace_rec_t      open_rec [n_hart];  // model of the record being collected
    logic            open_act [n_hart];
    int              stg [n_hart];       // position in the instruction, 0 is fetch
    logic [xlen-1:0] pend_rdt;           // response owed to the last transfer
    int              n_xfer;
    int              n_mis;
    int              n_other;
    logic            stall_en;           // random out_rdy stalls
    logic            hold_rdy;           // out_rdy held low

    trace_top DUT (.*);

    initial begin
        tcb = 1'b0;
        forever #10 tcb = ~tcb;
    end

////////////////////
// reference model

    // fold one transfer into the record of its hart
    function automatic trace_rec_t expected_rec(input trace_rec_t cur, input bus_req_t req,
                                                input logic [xlen-1:0] rdt);
        trace_rec_t r;
        r = cur;
        case (phase_e'(req.pha))
            ph_if: begin
                r = '0;  // wb and ls cleared
                r.hart    = req.hart;
                r.pc      = req.adr;
                r.ins     = rdt;
                r.ls_kind = ls_none;
            end
            ph_wb: begin
                r.wb_ena = 1'b1;
                r.wb_idx = req.adr[6:2];
                r.wb_dat = req.wdt;
            end
            ph_mld: begin
                r.ls_kind = ls_load;
                r.ls_adr  = req.adr;
                r.ls_siz  = req.siz;
                r.ls_dat  = rdt;
            end
            ph_mst: begin
                r.ls_kind = ls_store;
                r.ls_adr  = req.adr;
                r.ls_siz  = req.siz;
                r.ls_dat  = req.wdt;
            end
            default: begin
                // rs1, rs2, exe change nothing
            end
        endcase
        return r;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int h = 0; h < n_hart; h++) begin
            n += exp_q[h].size();
        end
        return n;
    endfunction

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, want);
            n_mis++;
        end
    endtask

////////////////////
// bus model

    function automatic bus_req_t make_req(input int h, input phase_e pha,
                                          input logic [xlen-1:0] adr,
                                          input logic [xlen-1:0] wdt, input logic [1:0] siz);
        bus_req_t r;
        r.hart = hart_w'(h);
        r.pha  = pha;
        r.wen  = (pha == ph_mst) || (pha == ph_wb);
        r.siz  = siz;
        r.adr  = adr;
        r.wdt  = wdt;
        return r;
    endfunction

    task automatic send(input bus_req_t req, input logic [xlen-1:0] rdt);
        int   h;
        logic rdy;
        h = int'(req.hart);
        if ((req.pha == ph_if) && open_act[h]) begin
            exp_q[h].push_back(open_rec[h]);  // fetch closes the open instruction
        end
        if (req.pha == ph_if) begin
            open_act[h] = 1'b1;
        end
        open_rec[h] = expected_rec(open_rec[h], req, rdt);
        n_xfer++;
        rdy = 1'b0;
        while (!rdy) begin
            @(posedge tcb);
            rdy = ($urandom_range(3) != 0);  // bus busy about one cycle in four
            bus_vld <= 1'b1;
            bus_rdy <= rdy;
            bus_req <= req;
            bus_rsp <= '{rdt: pend_rdt};  // answers the previous transfer
            if (rdy) begin
                pend_rdt = rdt;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge tcb);
        bus_vld <= 1'b0;
        bus_rdy <= ($urandom_range(1) == 1);  // ready alone is no transfer
        bus_rsp <= '{rdt: pend_rdt};
    endtask

    // next phase of hart h: fetch, rs1, rs2, exe, optional memory, optional wb
    task automatic issue_next(input int h);
        int     k;
        phase_e pha;
        k = stg[h];
        if ((k == 4) && ($urandom_range(2) == 0)) begin
            k = 5;
        end
        if ((k == 5) && ($urandom_range(1) == 0)) begin
            k = 0;
        end
        case (k)
            0: pha = ph_if;
            1: pha = ph_rs1;
            2: pha = ph_rs2;
            3: pha = ph_exe;
            4: pha = ($urandom_range(1) == 1) ? ph_mst : ph_mld;
            default: pha = ph_wb;
        endcase
        stg[h] = (k + 1) % 6;
        send(make_req(h, pha, $urandom, $urandom, 2'($urandom_range(2))), $urandom);
    endtask

    task automatic run_random();
        repeat (n_rand) begin
            if ($urandom_range(7) == 0) begin
                idle_cycle();
            end
            issue_next(int'($urandom_range(n_hart - 1)));
        end
    endtask

    task automatic wait_drain();
        while ((pending() != 0) || out_vld) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
    endtask

////////////////////
// output side

    initial begin : sink
        logic low;
        forever begin
            @(posedge tcb);
            low = hold_rdy || (stall_en && out_rdy && ($urandom_range(3) == 0));
            out_rdy <= !low;  // stalls never last two cycles
        end
    end

    initial begin : compare
        trace_rec_t want;
        int         h;
        forever begin
            @(negedge tcb);
            if (rst_n && out_vld && out_rdy) begin
                h = int'(out_rec.hart);
                if (exp_q[h].size() == 0) begin
                    $display("error at %0t: record from hart %0d was not expected", $time, h);
                    n_other++;
                end else begin
                    want = exp_q[h].pop_front();
                    check("out_rec", out_rec, want);
                end
            end
        end
    end

    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc <= n_xfer * 10 + 2000) begin
            @(posedge tcb);
            cyc++;
        end
        $display("timeout: run still busy after %0d cycles", cyc);
        $display(">>> FAIL");
        $finish;
    end

////////////////////
// test sequence

    initial begin : main
        void'($urandom(32'hae03_e43f));
        rst_n    = 1'b0;
        bus_vld  = 1'b0;
        bus_rdy  = 1'b0;
        bus_req  = '0;
        bus_rsp  = '0;
        out_rdy  = 1'b1;
        pend_rdt = '0;
        stall_en = 1'b0;
        hold_rdy = 1'b0;
        for (int h = 0; h < n_hart; h++) begin
            open_act[h] = 1'b0;
            open_rec[h] = '0;
            stg[h]      = 0;
        end
        repeat (5) @(posedge tcb);
        rst_n <= 1'b1;

        // directed on hart 2: wb only, load, store with reads and exe, bare fetch
        send(make_req(2, ph_if, 32'h0000_0100, '0, 2'd2), 32'h0050_0513);
        send(make_req(1, ph_if, 32'h0000_0800, '0, 2'd2), 32'h0000_0013);
        send(make_req(2, ph_wb, 32'h0000_0028, 32'h0000_0005, 2'd2), '0);
        send(make_req(2, ph_if, 32'h0000_0104, '0, 2'd2), 32'h0005_2583);
        send(make_req(2, ph_rs1, 32'h0000_0028, '0, 2'd2), 32'h0000_2000);
        send(make_req(2, ph_mld, 32'h0000_2000, '0, 2'd2), 32'hdead_0001);
        send(make_req(2, ph_wb, 32'h0000_002c, 32'hdead_0001, 2'd2), '0);
        send(make_req(2, ph_if, 32'h0000_0108, '0, 2'd2), 32'h00b5_00a3);
        send(make_req(2, ph_rs1, 32'h0000_0028, '0, 2'd2), 32'h0000_3000);
        send(make_req(2, ph_rs2, 32'h0000_002c, '0, 2'd2), 32'h0000_beef);
        send(make_req(2, ph_mst, 32'h0000_3001, 32'h0000_beef, 2'd0), '0);
        send(make_req(2, ph_exe, 32'h0000_0000, '0, 2'd2), '0);
        send(make_req(2, ph_if, 32'h0000_010c, '0, 2'd2), 32'h0000_0013);
        send(make_req(2, ph_if, 32'h0000_0110, '0, 2'd2), 32'h0000_0013);
        wait_drain();

        // all harts interleaved, then again with output stalls
        run_random();
        wait_drain();
        stall_en = 1'b1;
        run_random();
        wait_drain();
        stall_en = 1'b0;
        for (int h = 0; h < n_hart; h++) begin
            check($sformatf("drop_cnt[%0d]", h), drop_cnt[h], '0);
        end

        // hart 0 retires five with out_rdy low: out reg and slot keep two, three drop
        send(make_req(0, ph_if, 32'h0000_1ffc, '0, 2'd2), 32'h0000_0013);
        wait_drain();
        hold_rdy = 1'b1;
        idle_cycle();
        idle_cycle();
        for (int i = 0; i < 5; i++) begin
            send(make_req(0, ph_if, 32'h0000_2000 + 32'(4 * i), '0, 2'd2), 32'h00a0_0093);
            send(make_req(0, ph_wb, 32'(4 * (i + 1)), 32'(100 + i), 2'd2), '0);
        end
        repeat (6) idle_cycle();
        check("drop_cnt[0]", drop_cnt[0], 3);
        repeat (3) void'(exp_q[0].pop_back());  // the dropped ones
        hold_rdy = 1'b0;
        wait_drain();

        for (int h = 0; h < n_hart; h++) begin
            if (exp_q[h].size() != 0) begin
                $display("error: %0d records of hart %0d never came out", exp_q[h].size(), h);
                n_other++;
            end
        end
        $display("errors: %0d value mismatches, %0d other", n_mis, n_other);
        if ((n_mis + n_other) == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
source/trace_pkg.sv
source/trace_router.sv
source/trace_assembler.sv
source/trace_arbiter.sv
source/trace_top.sv
tests/tb_trace_top.sv

// File: run.sh
#!/bin/sh
# build the trace unit testbench with Verilator, run it, look for the pass line
verilator --binary --timing -Wno-fatal --top-module tb_trace_top -f build.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_trace_top)
echo "$out"
echo "$out" | grep -q "^>>> PASS$" && echo "run passed" || { echo "run failed"; exit 1; }
